// File: video_pkg.sv
// beam position type and default raster timing used by the counter and the copper engine
package video_pkg;

    // beam column or line, wide enough for any supported mode
    typedef logic [11:0] raster_t;

    // default 640x480 style totals
    // visible area plus blanking, in pixels per line
    localparam int H_TOTAL_DEF = 800;
    // lines per frame including vertical blanking
    localparam int V_TOTAL_DEF = 525;

endpackage

// File: copper_pkg.sv
// copper instruction word, opcodes and program memory layout shared by the coprocessor blocks
package copper_pkg;

    // one program word holds opcode in [15:12] and operand in [11:0]
    typedef logic [15:0] word_t;
    typedef logic [3:0]  opcode_t;

    // default program memory address width in words
    localparam int COPPER_AWIDTH = 10;

    // wait for line at or past operand
    localparam opcode_t OP_WAITV = 4'h0;
    // wait for column at or past operand
    localparam opcode_t OP_WAITH = 4'h1;
    // operand[3:0] selects register, next word carries data
    localparam opcode_t OP_MOVE  = 4'h2;
    // operand is the new program counter
    localparam opcode_t OP_JUMP  = 4'h3;
    // stop until the next frame start
    localparam opcode_t OP_END   = 4'hF;

    // erased memory reads back as END so a blank program does nothing
    localparam word_t END_WORD = {OP_END, 12'h000};

    // info block sits in the top INFO_WORDS words of program memory
    localparam int INFO_WORDS    = 8;
    localparam int INFO_ID_WORDS = 6;

    // version in BCD, major in high byte
    localparam word_t INFO_VERSION = 16'h0102;
    localparam word_t INFO_BUILD   = 16'hB41F;

    // two ascii characters per word, first character in the high byte
    localparam logic [16*INFO_ID_WORDS-1:0] INFO_ID = "COPPER-RAST1";

endpackage

// File: copper_mem.sv
// copper program memory with one write port, one registered read port and preset contents
module copper_mem
    import copper_pkg::*;
#(
    parameter int AWIDTH = COPPER_AWIDTH
) (
    input  logic              clk,
    input  logic [AWIDTH-1:0] rd_address_i,
    output word_t             rd_data_o,
    input  logic              wr_en_i,
    input  logic [AWIDTH-1:0] wr_address_i,
    input  word_t             wr_data_i
);

    localparam int DEPTH = 2**AWIDTH;
    // first word of the info block
    localparam int INFO_BASE = DEPTH - INFO_WORDS;

    word_t mem [0:DEPTH-1];

    // power-up image
    initial begin
        // unused program space decodes as END
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = END_WORD;
        end
        // id string first, high word of the string at the lowest address
        for (int i = 0; i < INFO_ID_WORDS; i++) begin
            mem[INFO_BASE + i] = INFO_ID[16*(INFO_ID_WORDS-1-i) +: 16];
        end
        // version and build close the block
        mem[DEPTH-2] = INFO_VERSION;
        mem[DEPTH-1] = INFO_BUILD;
    end

    // write lands on the clock edge
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_address_i] <= wr_data_i;
        end
    end

    // registered read, data one cycle after the address
    // same-address collision forwards the new word, matching the block RAM
    always_ff @(posedge clk) begin
        if (wr_en_i && (rd_address_i == wr_address_i)) begin
            rd_data_o <= wr_data_i;
        end else begin
            rd_data_o <= mem[rd_address_i];
        end
    end

endmodule

// File: raster_counter.sv
// beam column and line counters that give the copper its raster reference and frame start
module raster_counter
    import video_pkg::*;
#(
    parameter int H_TOTAL = H_TOTAL_DEF,
    parameter int V_TOTAL = V_TOTAL_DEF
) (
    input  logic    clk,
    input  logic    rst_n_i,
    output raster_t h_pos_o,
    output raster_t v_pos_o,
    output logic    frame_start_o
);

    // last column and last line before wrap
    localparam raster_t H_LAST = raster_t'(H_TOTAL - 1);
    localparam raster_t V_LAST = raster_t'(V_TOTAL - 1);

    raster_t h_q;
    raster_t v_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            h_q <= '0;
            v_q <= '0;
        end else if (h_q == H_LAST) begin
            // end of line, step to the next line
            h_q <= '0;
            if (v_q == V_LAST) begin
                v_q <= '0;
            end else begin
                v_q <= v_q + 1'b1;
            end
        end else begin
            h_q <= h_q + 1'b1;
        end
    end

    assign h_pos_o = h_q;
    assign v_pos_o = v_q;
    // top-left pixel of the frame
    assign frame_start_o = (h_q == '0) && (v_q == '0);

endmodule

// File: copper_engine.sv
// copper fetch and execute FSM that also shares its memory read port with host reads
module copper_engine
    import copper_pkg::*;
    import video_pkg::*;
#(
    parameter int AWIDTH  = COPPER_AWIDTH,
    parameter int H_TOTAL = H_TOTAL_DEF,
    parameter int V_TOTAL = V_TOTAL_DEF
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              enable_i,
    input  logic              frame_start_i,
    input  raster_t           h_pos_i,
    input  raster_t           v_pos_i,
    output logic [AWIDTH-1:0] mem_raddr_o,
    input  word_t             mem_rdata_i,
    input  logic              host_rd_req_i,
    input  logic [AWIDTH-1:0] host_rd_addr_i,
    output logic              host_rd_valid_o,
    output logic [AWIDTH-1:0] pc_o,
    output logic              reg_wr_o,
    output logic [3:0]        reg_addr_o,
    output word_t             reg_data_o
);

    // S_FETCH and S_MOVE drive the read port, S_DATA consumes the word
    typedef enum logic [2:0] {
        S_FETCH,
        S_DATA,
        S_WAIT,
        S_MOVE,
        S_END
    } state_t;

    state_t            state;
    logic [AWIDTH-1:0] pc;
    logic              data_phase;
    logic              host_slot;
    logic [AWIDTH-1:0] host_addr_q;
    opcode_t           op;
    logic [11:0]       operand;
    logic              wait_ok;
    logic              wait_vert;
    raster_t           wait_pos;
    logic              wait_hit;
    logic [3:0]        move_reg;

    // decode straight off the memory output
    assign op      = mem_rdata_i[15:12];
    assign operand = mem_rdata_i[11:0];

    // a wait beyond the frame can never match
    assign wait_ok = (op == OP_WAITV) ? (operand < 12'(V_TOTAL)) : (operand < 12'(H_TOTAL));
    assign wait_hit = wait_vert ? (v_pos_i >= wait_pos) : (h_pos_i >= wait_pos);

    // host owns the port for exactly one cycle after its request
    assign mem_raddr_o = host_slot ? host_addr_q : pc;
    assign pc_o        = pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            host_slot       <= 1'b0;
            host_rd_valid_o <= 1'b0;
        end else begin
            host_slot       <= host_rd_req_i;
            // data for the slot appears one cycle later
            host_rd_valid_o <= host_slot;
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd_req_i) begin
            host_addr_q <= host_rd_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state      <= S_END;
            pc         <= '0;
            data_phase <= 1'b0;
            reg_wr_o   <= 1'b0;
        end else begin
            reg_wr_o <= 1'b0;
            if (!enable_i) begin
                // parked at 0, nothing runs
                state      <= S_END;
                pc         <= '0;
                data_phase <= 1'b0;
            end else if (frame_start_i) begin
                // program restarts every frame
                state      <= S_FETCH;
                pc         <= '0;
                data_phase <= 1'b0;
            end else begin
                case (state)
                    S_FETCH: begin
                        // stall while the host holds the port, replay next cycle
                        if (!host_slot) begin
                            state <= S_DATA;
                        end
                    end
                    S_DATA: begin
                        if (data_phase) begin
                            // second word of MOVE, issue the register write
                            reg_wr_o   <= 1'b1;
                            pc         <= pc + 1'b1;
                            data_phase <= 1'b0;
                            state      <= S_FETCH;
                        end else begin
                            case (op)
                                OP_WAITV, OP_WAITH: begin
                                    pc    <= pc + 1'b1;
                                    state <= wait_ok ? S_WAIT : S_END;
                                end
                                OP_MOVE: begin
                                    pc    <= pc + 1'b1;
                                    state <= S_MOVE;
                                end
                                OP_JUMP: begin
                                    pc    <= operand[AWIDTH-1:0];
                                    state <= S_FETCH;
                                end
                                // END and unknown opcodes idle out the frame
                                default: state <= S_END;
                            endcase
                        end
                    end
                    S_WAIT: begin
                        if (wait_hit) begin
                            state <= S_FETCH;
                        end
                    end
                    S_MOVE: begin
                        // fetch the data word, same stall rule as S_FETCH
                        if (!host_slot) begin
                            data_phase <= 1'b1;
                            state      <= S_DATA;
                        end
                    end
                    default: state <= S_END;
                endcase
            end
        end
    end

    // operand capture for waits and moves
    always_ff @(posedge clk) begin
        if ((state == S_DATA) && !data_phase) begin
            wait_vert <= (op == OP_WAITV);
            wait_pos  <= operand;
            move_reg  <= operand[3:0];
        end
        if ((state == S_DATA) && data_phase) begin
            reg_addr_o <= move_reg;
            reg_data_o <= mem_rdata_i;
        end
    end

endmodule

// File: axil_host_port.sv
// AXI4-Lite slave that loads program words, reads memory through the engine and holds control
module axil_host_port
    import copper_pkg::*;
#(
    parameter int AWIDTH = COPPER_AWIDTH
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              awvalid_i,
    output logic              awready_o,
    input  logic [15:0]       awaddr_i,
    input  logic              wvalid_i,
    output logic              wready_o,
    input  logic [31:0]       wdata_i,
    output logic              bvalid_o,
    input  logic              bready_i,
    output logic [1:0]        bresp_o,
    input  logic              arvalid_i,
    output logic              arready_o,
    input  logic [15:0]       araddr_i,
    output logic              rvalid_o,
    input  logic              rready_i,
    output logic [31:0]       rdata_o,
    output logic [1:0]        rresp_o,
    output logic              mem_wr_o,
    output logic [AWIDTH-1:0] mem_waddr_o,
    output word_t             mem_wdata_o,
    output logic              host_rd_req_o,
    output logic [AWIDTH-1:0] host_rd_addr_o,
    input  logic              host_rd_valid_i,
    input  word_t             mem_rdata_i,
    input  logic [AWIDTH-1:0] pc_i,
    output logic              enable_o
);

    // program words live below the control register
    localparam logic [15:0] CTRL_ADDR = 16'h1000;
    localparam logic [1:0]  RESP_OKAY = 2'b00;

    logic        wr_accept;
    logic        wr_pend;
    logic        rd_accept;
    logic        rd_pend;
    logic        aw_is_mem;
    logic        aw_is_ctrl;
    logic        ar_is_mem;
    logic        ar_is_ctrl;
    logic [31:0] status_word;

    // AW and W always transfer together
    assign awready_o = wr_accept;
    assign wready_o  = wr_accept;
    assign arready_o = rd_accept;
    assign bresp_o   = RESP_OKAY;
    assign rresp_o   = RESP_OKAY;

    assign aw_is_mem  = awaddr_i < CTRL_ADDR;
    assign aw_is_ctrl = awaddr_i == CTRL_ADDR;
    assign ar_is_mem  = araddr_i < CTRL_ADDR;
    assign ar_is_ctrl = araddr_i == CTRL_ADDR;

    // enable in bit 0, program counter in [27:16]
    assign status_word = {4'h0, 12'(pc_i), 15'h0, enable_o};

    // write path
    // accept -> memory write strobe -> bvalid, two cycles in all
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_accept <= 1'b0;
            wr_pend   <= 1'b0;
            mem_wr_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            enable_o  <= 1'b0;
        end else begin
            // one-cycle ready, held off while a response is outstanding
            wr_accept <= awvalid_i && wvalid_i && !wr_accept && !wr_pend && !bvalid_o;
            wr_pend   <= wr_accept;
            mem_wr_o  <= wr_accept && aw_is_mem;
            if (wr_accept && aw_is_ctrl) begin
                enable_o <= wdata_i[0];
            end
            if (wr_pend) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
        end
    end

    // only the low half of the bus carries a program word
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem_waddr_o <= awaddr_i[AWIDTH+1:2];
            mem_wdata_o <= wdata_i[15:0];
        end
    end

    // read path
    // memory reads go through the engine slot, control reads answer next cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rd_accept     <= 1'b0;
            rd_pend       <= 1'b0;
            host_rd_req_o <= 1'b0;
            rvalid_o      <= 1'b0;
        end else begin
            rd_accept     <= arvalid_i && !rd_accept && !rd_pend && !rvalid_o;
            host_rd_req_o <= rd_accept && ar_is_mem;
            if (rd_accept && ar_is_mem) begin
                rd_pend <= 1'b1;
            end else if (host_rd_valid_i) begin
                rd_pend <= 1'b0;
            end
            if (rd_accept && !ar_is_mem) begin
                rvalid_o <= 1'b1;
            end else if (rd_pend && host_rd_valid_i) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            host_rd_addr_o <= araddr_i[AWIDTH+1:2];
            // unmapped addresses read as zero
            rdata_o        <= ar_is_ctrl ? status_word : 32'h0;
        end else if (rd_pend && host_rd_valid_i) begin
            rdata_o <= {16'h0, mem_rdata_i};
        end
    end

endmodule

// File: copper_top.sv
// copper coprocessor top level joining host port, program memory, engine and raster counter
module copper_top
    import copper_pkg::*;
    import video_pkg::*;
#(
    parameter int AWIDTH  = COPPER_AWIDTH,
    parameter int H_TOTAL = H_TOTAL_DEF,
    parameter int V_TOTAL = V_TOTAL_DEF
) (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [15:0] awaddr_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    input  logic [31:0] wdata_i,
    output logic        bvalid_o,
    input  logic        bready_i,
    output logic [1:0]  bresp_o,
    input  logic        arvalid_i,
    output logic        arready_o,
    input  logic [15:0] araddr_i,
    output logic        rvalid_o,
    input  logic        rready_i,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        reg_wr_o,
    output logic [3:0]  reg_addr_o,
    output word_t       reg_data_o,
    output raster_t     h_pos_o,
    output raster_t     v_pos_o,
    output logic        frame_start_o
);

    // host write port into memory
    logic              mem_wr;
    logic [AWIDTH-1:0] mem_waddr;
    word_t             mem_wdata;
    // shared read port, arbitrated in the engine
    logic [AWIDTH-1:0] mem_raddr;
    word_t             mem_rdata;
    logic              host_rd_req;
    logic [AWIDTH-1:0] host_rd_addr;
    logic              host_rd_valid;
    // control and status
    logic              enable;
    logic [AWIDTH-1:0] pc;

    axil_host_port #(
        .AWIDTH(AWIDTH)
    ) axil_host_port_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .awvalid_i      (awvalid_i),
        .awready_o      (awready_o),
        .awaddr_i       (awaddr_i),
        .wvalid_i       (wvalid_i),
        .wready_o       (wready_o),
        .wdata_i        (wdata_i),
        .bvalid_o       (bvalid_o),
        .bready_i       (bready_i),
        .bresp_o        (bresp_o),
        .arvalid_i      (arvalid_i),
        .arready_o      (arready_o),
        .araddr_i       (araddr_i),
        .rvalid_o       (rvalid_o),
        .rready_i       (rready_i),
        .rdata_o        (rdata_o),
        .rresp_o        (rresp_o),
        .mem_wr_o       (mem_wr),
        .mem_waddr_o    (mem_waddr),
        .mem_wdata_o    (mem_wdata),
        .host_rd_req_o  (host_rd_req),
        .host_rd_addr_o (host_rd_addr),
        .host_rd_valid_i(host_rd_valid),
        .mem_rdata_i    (mem_rdata),
        .pc_i           (pc),
        .enable_o       (enable)
    );

    copper_mem #(
        .AWIDTH(AWIDTH)
    ) copper_mem_i (
        .clk         (clk),
        .rd_address_i(mem_raddr),
        .rd_data_o   (mem_rdata),
        .wr_en_i     (mem_wr),
        .wr_address_i(mem_waddr),
        .wr_data_i   (mem_wdata)
    );

    copper_engine #(
        .AWIDTH (AWIDTH),
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) copper_engine_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .enable_i       (enable),
        .frame_start_i  (frame_start_o),
        .h_pos_i        (h_pos_o),
        .v_pos_i        (v_pos_o),
        .mem_raddr_o    (mem_raddr),
        .mem_rdata_i    (mem_rdata),
        .host_rd_req_i  (host_rd_req),
        .host_rd_addr_i (host_rd_addr),
        .host_rd_valid_o(host_rd_valid),
        .pc_o           (pc),
        .reg_wr_o       (reg_wr_o),
        .reg_addr_o     (reg_addr_o),
        .reg_data_o     (reg_data_o)
    );

    raster_counter #(
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) raster_counter_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .h_pos_o      (h_pos_o),
        .v_pos_o      (v_pos_o),
        .frame_start_o(frame_start_o)
    );

endmodule

// File: copper_sva.sv
// assertions on the copper AXI handshakes and register write strobe, bound into copper_top
module copper_sva (
    input logic        clk,
    input logic        rst_n_i,
    input logic        awvalid_i,
    input logic        awready_o,
    input logic        wvalid_i,
    input logic        wready_o,
    input logic        bvalid_o,
    input logic        bready_i,
    input logic        arready_o,
    input logic        rvalid_o,
    input logic        rready_i,
    input logic [31:0] rdata_o,
    input logic        reg_wr_o,
    input logic [3:0]  reg_addr_o,
    input logic [15:0] reg_data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // ready only answers an address and data that are both offered
    aw_w_offered: assert property (@(posedge clk) disable iff (!rst_n_i)
        (awready_o || wready_o) |-> (awvalid_i && wvalid_i))
        else $error("awready or wready without both awvalid and wvalid");

    // write response waits for bready
    b_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o) else $error("bvalid dropped before bready");

    // read response and its data hold under back-pressure
    r_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o))
        else $error("rvalid or rdata changed before rready");

    // no new write while its response is outstanding
    b_blocks_aw: assert property (@(posedge clk) disable iff (!rst_n_i)
        bvalid_o |-> !awready_o) else $error("write accepted while bvalid pending");

    // no new read while its response is outstanding
    r_blocks_ar: assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid_o |-> !arready_o) else $error("read accepted while rvalid pending");

    // each MOVE ends in a single strobe with known address and data
    reg_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_wr_o |-> !$isunknown({reg_addr_o, reg_data_o}) ##1 !reg_wr_o)
        else $error("register write strobe longer than one cycle or unknown");

endmodule

bind copper_top copper_sva copper_sva_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .arready_o (arready_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_o   (rdata_o),
    .reg_wr_o  (reg_wr_o),
    .reg_addr_o(reg_addr_o),
    .reg_data_o(reg_data_o)
);

// File: copper_tb.sv
// copper testbench, replays copper_golden.mem against copper_top over AXI and the register port
module copper_tb
    import copper_pkg::*;
    import video_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // short frames keep the run small
    localparam int H_TOT      = 32;
    localparam int V_TOT      = 12;
    localparam int GOLD_DEPTH = 256;
    localparam int KIND_WRITE = 1;
    localparam int KIND_READ  = 2;
    localparam int KIND_MOVE  = 3;
    localparam int KIND_FRAME = 4;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        awvalid_i;
    logic        awready_o;
    logic [15:0] awaddr_i;
    logic        wvalid_i;
    logic        wready_o;
    logic [31:0] wdata_i;
    logic        bvalid_o;
    logic        bready_i;
    logic [1:0]  bresp_o;
    logic        arvalid_i;
    logic        arready_o;
    logic [15:0] araddr_i;
    logic        rvalid_o;
    logic        rready_i;
    logic [31:0] rdata_o;
    logic [1:0]  rresp_o;
    logic        reg_wr_o;
    logic [3:0]  reg_addr_o;
    word_t       reg_data_o;
    raster_t     h_pos_o;
    raster_t     v_pos_o;
    logic        frame_start_o;

    logic [31:0] golden [0:GOLD_DEPTH-1];
    // observed register writes as {line, reg, data}
    logic [31:0] wr_q [$];
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;
    // beam position expected from the cycles since reset
    int unsigned beam_cnt = 0;

    copper_top #(
        .AWIDTH (COPPER_AWIDTH),
        .H_TOTAL(H_TOT),
        .V_TOTAL(V_TOT)
    ) copper_top_i (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // watchdog, limit comes from the frame counts in the golden file
    always @(posedge clk) begin
        cycles++;
        if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
            fail_run($sformatf("timeout after %0d cycles waiting for the DUT", cycles));
        end
    end

    // strobe values before the edge belong to the cycle that just ended
    always @(posedge clk) begin
        if (rst_n_i && reg_wr_o) begin
            wr_q.push_back({v_pos_o, reg_addr_o, reg_data_o});
        end
    end

    task automatic check_rdata(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_pos(input string name, input raster_t got, input raster_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0d ns: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // a write may land late in the frame but never before its wait line
    task automatic check_line(input string name, input raster_t got, input raster_t min_line);
        if (got < min_line) begin
            fail_run($sformatf("error at %0d ns: %s got %0d expected at least %0d",
                $time, name, got, min_line));
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n_i) begin
            beam_cnt <= 0;
        end else begin
            beam_cnt <= beam_cnt + 1;
        end
    end

    // h steps every cycle, v steps on each wrap of h, frame start at the origin
    always @(negedge clk) begin
        check_pos("h_pos_o", h_pos_o, raster_t'(beam_cnt % H_TOT));
        check_pos("v_pos_o", v_pos_o, raster_t'((beam_cnt / H_TOT) % V_TOT));
        check_flag("frame_start_o", frame_start_o, (beam_cnt % (H_TOT * V_TOT)) == 0);
    end

    // every bus task starts and ends on a falling edge
    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
        int stall;
        stall = $urandom % 4;
        awaddr_i  = addr;
        wdata_i   = data;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        // ready seen here means the transfer happens on the next rising edge
        do @(negedge clk); while (!awready_o && !wready_o);
        check_flag("awready_o", awready_o, 1'b1);
        check_flag("wready_o", wready_o, 1'b1);
        @(negedge clk);
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        while (!bvalid_o) @(negedge clk);
        repeat (stall) @(negedge clk);
        check_resp("bresp_o", bresp_o, 2'b00);
        bready_i = 1'b1;
        @(negedge clk);
        bready_i = 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
        int stall;
        stall = $urandom % 4;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        do @(negedge clk); while (!arready_o);
        @(negedge clk);
        arvalid_i = 1'b0;
        // control reads may already be answered here
        while (!rvalid_o) @(negedge clk);
        repeat (stall) @(negedge clk);
        check_resp("rresp_o", rresp_o, 2'b00);
        data     = rdata_o;
        rready_i = 1'b1;
        @(negedge clk);
        rready_i = 1'b0;
    endtask

    task automatic expect_reg_write(input logic [3:0] reg_num, input word_t data,
                                    input raster_t min_line);
        logic [31:0] entry;
        while (wr_q.size() == 0) @(negedge clk);
        entry = wr_q.pop_front();
        check_reg("reg_addr_o", entry[19:16], reg_num);
        check_word("reg_data_o", entry[15:0], data);
        check_line("v_pos_o", entry[31:20], min_line);
    endtask

    // quiet means no register write may show up before the last frame start
    task automatic wait_frames(input int count, input logic quiet);
        int seen;
        seen = 0;
        while (seen < count) begin
            @(negedge clk);
            if (frame_start_o) begin
                seen++;
            end
        end
        if (quiet && (wr_q.size() != 0)) begin
            fail_run($sformatf("register write to %0d with data %h where none may occur",
                wr_q[0][19:16], wr_q[0][15:0]));
        end
    endtask

    initial begin
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic [31:0] rd;
        int          idx;
        int          frames;
        void'($urandom(47383));
        rst_n_i   = 1'b0;
        awvalid_i = 1'b0;
        awaddr_i  = '0;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        bready_i  = 1'b0;
        arvalid_i = 1'b0;
        araddr_i  = '0;
        rready_i  = 1'b0;
        $readmemh("copper_golden.mem", golden);
        if (golden[0] === 'x) begin
            fail_run("golden file copper_golden.mem could not be read");
        end
        // sum of frame waits sets the run length
        frames = 0;
        for (idx = 0; (idx < GOLD_DEPTH) && (golden[idx] !== 32'd0); idx += 4) begin
            if (golden[idx] === KIND_FRAME) begin
                frames += int'(golden[idx+2]);
            end
        end
        cycle_limit = 8 * frames * H_TOT * V_TOT + 2000;
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        for (idx = 0; idx < GOLD_DEPTH; idx += 4) begin
            kind    = golden[idx];
            addr    = golden[idx+1];
            data    = golden[idx+2];
            exp_val = golden[idx+3];
            if (kind === 32'd0) begin
                break;
            end
            case (kind)
                KIND_WRITE: axi_write(addr[15:0], data);
                KIND_READ: begin
                    axi_read(addr[15:0], rd);
                    check_rdata("rdata_o", rd, exp_val);
                end
                KIND_MOVE:  expect_reg_write(addr[3:0], data[15:0], exp_val[11:0]);
                KIND_FRAME: wait_frames(int'(data), exp_val[0]);
                default: fail_run($sformatf("unknown record kind %h in the golden file", kind));
            endcase
        end
        // any write not claimed by a record is an extra one
        if (wr_q.size() != 0) begin
            fail_run($sformatf("%0d register writes left without a matching record", wr_q.size()));
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: copper_golden.mem
// records of four words: kind address data expected
// kind 1 AXI write, 2 AXI read, 3 register write (reg, data, min line), 4 frames (count, quiet), 0 end
// info block and an erased word after reset
00000002 00000FE0 00000000 0000434F
00000002 00000FE4 00000000 00005050
00000002 00000FE8 00000000 00004552
00000002 00000FEC 00000000 00002D52
00000002 00000FF0 00000000 00004153
00000002 00000FF4 00000000 00005431
00000002 00000FF8 00000000 00000102
00000002 00000FFC 00000000 0000B41F
00000002 00000000 00000000 0000F000
// program: waitv 2, move r1, move r2, waitv 5, move r3, jump over r7, waitv 8, waith 16, move r15, end
00000001 00000000 00000002 00000000
00000001 00000004 00002001 00000000
00000001 00000008 00001111 00000000
00000001 0000000C 00002002 00000000
00000001 00000010 00002222 00000000
00000001 00000014 00000005 00000000
00000001 00000018 00002003 00000000
00000001 0000001C 0000A5A5 00000000
00000001 00000020 0000300B 00000000
00000001 00000024 00002007 00000000
00000001 00000028 1234DEAD 00000000
00000001 0000002C 00000008 00000000
00000001 00000030 00001010 00000000
00000001 00000034 0000200F 00000000
00000001 00000038 00000F0F 00000000
00000001 0000003C 0000F000 00000000
// readback, upper half of word 10 was dropped
00000002 00000004 00000000 00002001
00000002 00000028 00000000 0000DEAD
00000002 0000003C 00000000 0000F000
00000002 00001000 00000000 00000000
// enable, then two frames of writes with a memory read in the middle
00000001 00001000 00000001 00000000
00000003 00000001 00001111 00000002
00000003 00000002 00002222 00000002
00000003 00000003 0000A5A5 00000005
00000003 0000000F 00000F0F 00000008
00000003 00000001 00001111 00000002
00000002 00000018 00000000 00002003
00000003 00000002 00002222 00000002
00000003 00000003 0000A5A5 00000005
00000003 0000000F 00000F0F 00000008
// end holds off writes until the next frame start
00000004 00000000 00000001 00000001
00000003 00000001 00001111 00000002
00000003 00000002 00002222 00000002
00000003 00000003 0000A5A5 00000005
00000003 0000000F 00000F0F 00000008
// disable, two quiet frames, status shows enable 0 and pc 0
00000001 00001000 00000000 00000000
00000004 00000000 00000002 00000001
00000002 00001000 00000000 00000000
00000000 00000000 00000000 00000000

// File: verilog.f
video_pkg.sv
copper_pkg.sv
copper_mem.sv
raster_counter.sv
copper_engine.sv
axil_host_port.sv
copper_top.sv
copper_sva.sv
copper_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the copper testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module copper_tb -o copper_sim > build.log 2>&1 \
    && ./obj_dir/copper_sim > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
